/* Makefile */
VERILATOR ?= verilator
TOP       ?= codec_init_tb
FILELIST  ?= codec_init.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* codec_init.f */
common/codec_pkg.sv
common/i2c_pkg.sv
src/codec_init_regs.sv
src/init_sequencer.sv
i2c_master/i2c_write_engine.sv
src/codec_init_top.sv
dv/codec_init_asserts.sv
dv/codec_init_tb.sv

/* common/codec_pkg.sv */
package codec_pkg;

    // codec write address, forms the bus byte 0x34.
    localparam logic [6:0] CODEC_DEV_ADDR = 7'h1a;

    localparam int N_INIT_CMDS = 11;
    localparam int CMD_IDX_W   = 4;

    // host register map.
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_CLKDIV = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    typedef struct packed {
        logic [7:0] dev_byte;
        logic [7:0] reg_byte;
        logic [7:0] dat_byte;
    } codec_bytes_t;

    // data bit 8 lands in the low bit of reg_byte.
    typedef struct packed {
        logic [6:0] dev_addr;
        logic       rw;
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } codec_fields_t;

    typedef union packed {
        codec_bytes_t  bytes;
        codec_fields_t fields;
    } codec_cmd_u;

    typedef struct packed {
        logic [15-CMD_IDX_W-3:0] pad;
        logic [CMD_IDX_W-1:0]    cmd_idx;
        logic                    nack_err;
        logic                    done;
        logic                    busy;
    } status_t;

    function automatic codec_cmd_u make_write(input logic [6:0] addr, input logic [8:0] data);
        codec_cmd_u cmd;
        cmd.fields.dev_addr = CODEC_DEV_ADDR;
        cmd.fields.rw       = 1'b0;
        cmd.fields.reg_addr = addr;
        cmd.fields.reg_data = data;
        return cmd;
    endfunction

    // reset register first, then registers 0 to 9.
    localparam codec_cmd_u INIT_TABLE [N_INIT_CMDS] = '{
        make_write(7'd15, 9'h000),
        make_write(7'd0,  9'h097),
        make_write(7'd1,  9'h097),
        make_write(7'd2,  9'h079),
        make_write(7'd3,  9'h079),
        make_write(7'd4,  9'h015),
        make_write(7'd5,  9'h000),
        make_write(7'd6,  9'h000),
        make_write(7'd7,  9'h042),
        make_write(7'd8,  9'h019),
        make_write(7'd9,  9'h001)
    };

endpackage

/* common/i2c_pkg.sv */
package i2c_pkg;

    // write engine states.
    typedef enum logic [2:0] {
        IDLE,
        START,
        BIT,
        ACK,
        STOP,
        DONE
    } i2c_state_e;

    // three bytes per codec write: address, register, data.
    localparam int BYTES_PER_CMD = 3;
    localparam int BITS_PER_BYTE = 8;

    localparam int BYTE_CNT_W = $clog2(BYTES_PER_CMD);
    localparam int BIT_CNT_W  = $clog2(BITS_PER_BYTE);

endpackage

/* dv/codec_init_asserts.sv */
`timescale 1ns/100ps

module codec_init_asserts
    import i2c_pkg::*;
(
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_cmd_req,
    input logic        i_cmd_ack,
    input logic [23:0] i_cmd_word,
    input i2c_state_e  i_state,
    input logic        i_scl,
    input logic        i_sda_oe
);

    int fail_cnt = 0;

    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_cmd_ack) |-> i_cmd_req)
        else begin
            $error("cmd_ack rose without cmd_req");
            fail_cnt++;
        end

    // req may only drop once ack is seen.
    req_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_req && !i_cmd_ack |=> i_cmd_req)
        else begin
            $error("cmd_req dropped before cmd_ack");
            fail_cnt++;
        end

    word_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_req |=> $stable(i_cmd_word))
        else begin
            $error("cmd_word changed while cmd_req was high");
            fail_cnt++;
        end

    idle_levels: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_state == IDLE |-> i_scl && !i_sda_oe)
        else begin
            $error("bus not released while the engine is idle");
            fail_cnt++;
        end

endmodule

/* dv/codec_init_tb.sv */
`timescale 1ns/100ps

module codec_init_tb
    import codec_pkg::*;
();

    localparam int DIV_RESET  = 24;
    localparam int DIV_MAX    = 40;
    localparam int N_RUNS     = 4;
    // up to 4 full runs of 11 commands at about 30 bits and 4 quarters per bit, doubled.
    localparam int TIMEOUT_NS = 2 * N_RUNS * N_INIT_CMDS * 30 * 4 * (DIV_MAX + 1) * 10;

    localparam logic [6:0] EXP_REG [11] = '{7'd15, 7'd0, 7'd1, 7'd2, 7'd3, 7'd4,
                                            7'd5, 7'd6, 7'd7, 7'd8, 7'd9};
    localparam logic [8:0] EXP_DATA [11] = '{9'h000, 9'h097, 9'h097, 9'h079, 9'h079,
                                             9'h015, 9'h000, 9'h000, 9'h042, 9'h019, 9'h001};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        reg_wr;
    logic [1:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic        scl;
    logic        sda_oe;
    logic        slave_pull;
    wire         sda;

    string       test_name = "none";
    int          errors = 0;
    int          err_mark = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          cur_div = DIV_RESET;
    int unsigned seen = 0;
    int unsigned tr_count = 0;
    int unsigned bit_cnt = 0;
    int unsigned byte_cnt = 0;
    logic [7:0]  cur_byte;
    logic [23:0] cap_bits;
    logic        in_frame = 1'b0;
    logic [25:0] cap_q [$];
    event        frame_done;
    bit          nack_en = 1'b0;
    int unsigned nack_cmd = 0;
    int unsigned nack_byte = 0;
    time         rise_time = 0;
    bit          rise_valid = 1'b0;

    // wired-AND of master and slave.
    assign sda = !(sda_oe || slave_pull);

    always #5 clk = ~clk;

    codec_init_top #(
        .DIV_RESET (DIV_RESET)
    ) i_codec_init_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_reg_wr    (reg_wr),
        .i_reg_addr  (reg_addr),
        .i_reg_wdata (reg_wdata),
        .o_reg_rdata (reg_rdata),
        .o_scl       (scl),
        .o_sda_oe    (sda_oe),
        .i_sda       (sda)
    );

    bind i2c_write_engine codec_init_asserts i_codec_init_asserts (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd_req  (i_cmd_req),
        .i_cmd_ack  (o_cmd_ack),
        .i_cmd_word (i_cmd_word),
        .i_state    (state_q),
        .i_scl      (o_scl),
        .i_sda_oe   (o_sda_oe)
    );

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    // bus bytes are 0x34 then {register, data bit 8} then data[7:0].
    function automatic logic [23:0] expected_cmd(input int unsigned n);
        if (n >= 11) begin
            return 24'h0;
        end
        return {8'h34, EXP_REG[n], EXP_DATA[n][8], EXP_DATA[n][7:0]};
    endfunction

    function automatic logic [15:0] status_word(input int idx, input bit nack, input bit done);
        return {9'b0, 4'(idx), nack, done, 1'b0};
    endfunction

    ////////////////////////////////////////
    // bus slave model
    ////////////////////////////////////////

    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame   = 1'b1;
            bit_cnt    = 0;
            byte_cnt   = 0;
            cap_bits   = '0;
            rise_valid = 1'b0;
            tr_count++;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            in_frame = 1'b0;
            cap_q.push_back({2'(byte_cnt), cap_bits});
            -> frame_done;
        end
    end

    always @(posedge scl) begin
        rise_time  = $time;
        rise_valid = 1'b1;
        if (in_frame) begin
            if (bit_cnt < 8) begin
                cur_byte = {cur_byte[6:0], sda};
            end
            bit_cnt++;
            if (bit_cnt == 9) begin
                cap_bits = {cap_bits[15:0], cur_byte};
                byte_cnt++;
                bit_cnt = 0;
            end
        end
    end

    always @(negedge scl) begin
        if (rise_valid) begin
            check("scl high clocks", 2 * (cur_div + 1), int'(($time - rise_time) / 10));
        end
        rise_valid = 1'b0;
        // ack slot follows the eighth bit.
        if (in_frame && bit_cnt == 8 &&
            !(nack_en && tr_count == nack_cmd + 1 && byte_cnt == nack_byte)) begin
            slave_pull = 1'b1;
        end else begin
            slave_pull = 1'b0;
        end
    end

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////

    initial begin
        logic [25:0] cap;
        int unsigned nexp;
        forever begin
            @(frame_done);
            while (cap_q.size() != 0) begin
                cap  = cap_q.pop_front();
                nexp = (nack_en && seen == nack_cmd) ? nack_byte + 1 : 3;
                check("frame bytes", nexp, cap[25:24]);
                check("frame data", expected_cmd(seen) >> (8 * (3 - nexp)), cap[23:0]);
                seen++;
            end
        end
    end

    ////////////////////////////////////////
    // host tasks
    ////////////////////////////////////////

    task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [15:0] data);
        @(negedge clk);
        reg_addr = addr;
        #1;
        data = reg_rdata;
    endtask

    task automatic set_div(input int div);
        reg_write(REG_CLKDIV, 16'(div));
        cur_div = div;
    endtask

    task automatic start_seq();
        seen     = 0;
        tr_count = 0;
        reg_write(REG_CTRL, 16'h0001);
        @(negedge clk);
    endtask

    task automatic wait_idle();
        logic [15:0] st;
        reg_read(REG_STATUS, st);
        while (st[0]) begin
            reg_read(REG_STATUS, st);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (errors != err_mark) begin
            n_failed++;
        end
        $display("test %s finished with %0d errors", test_name, errors - err_mark);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin
        logic [15:0] rd;
        logic [31:0] rnd;
        rst_n      = 1'b0;
        reg_wr     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        slave_pull = 1'b0;
        void'($urandom(11326));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_values");
        check("scl", 1, scl);
        check("sda_oe", 0, sda_oe);
        reg_read(REG_STATUS, rd);
        check("status", 0, rd);
        reg_read(REG_CLKDIV, rd);
        check("clkdiv reset", DIV_RESET, rd);
        rnd = $urandom;
        reg_write(REG_CLKDIV, rnd[15:0]);
        reg_read(REG_CLKDIV, rd);
        check("clkdiv readback", rnd[15:0], rd);
        set_div(DIV_RESET);
        end_test();

        begin_test("default_sequence");
        start_seq();
        wait_idle();
        check("frames", 11, tr_count);
        check("compared", 11, seen);
        reg_read(REG_STATUS, rd);
        check("status", status_word(10, 1'b0, 1'b1), rd);
        end_test();

        begin_test("random_divider");
        set_div($urandom_range(1, DIV_MAX));
        start_seq();
        wait_idle();
        check("frames", 11, tr_count);
        check("compared", 11, seen);
        end_test();

        begin_test("nack_stop");
        set_div($urandom_range(1, DIV_MAX));
        nack_cmd  = $urandom_range(0, N_INIT_CMDS - 1);
        nack_byte = $urandom_range(0, 2);
        nack_en   = 1'b1;
        start_seq();
        wait_idle();
        repeat (100) @(negedge clk);
        check("frames", nack_cmd + 1, tr_count);
        check("compared", nack_cmd + 1, seen);
        reg_read(REG_STATUS, rd);
        check("status", status_word(int'(nack_cmd), 1'b1, 1'b0), rd);
        nack_en = 1'b0;
        end_test();

        begin_test("restart_after_error");
        set_div(DIV_RESET);
        start_seq();
        reg_write(REG_CTRL, 16'h0001);
        repeat (20) @(negedge clk);
        reg_write(REG_CTRL, 16'h0001);
        wait_idle();
        repeat (100) @(negedge clk);
        check("frames", 11, tr_count);
        check("compared", 11, seen);
        reg_read(REG_STATUS, rd);
        check("status", status_word(10, 1'b0, 1'b1), rd);
        end_test();

        check("assertion failures", 0,
              i_codec_init_top.i_i2c_write_engine.i_codec_init_asserts.fail_cnt);
        $display("tests %0d, failing tests %0d, failed checks %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* i2c_master/i2c_write_engine.sv */
`timescale 1ns/100ps

module i2c_write_engine
    import codec_pkg::*;
    import i2c_pkg::*;
#(
    parameter int DIV_W = 16
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [DIV_W-1:0] i_clkdiv,
    input  logic             i_cmd_req,
    input  codec_cmd_u       i_cmd_word,
    input  logic             i_sda,
    output logic             o_cmd_ack,
    output logic             o_cmd_nack,
    output logic             o_scl,
    output logic             o_sda_oe
);

    localparam logic [BIT_CNT_W-1:0]  LAST_BIT  = BIT_CNT_W'(BITS_PER_BYTE - 1);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BYTES_PER_CMD - 1);

    i2c_state_e            state_q;
    logic [DIV_W-1:0]      qcnt_q;
    logic [1:0]            phase_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [BYTE_CNT_W-1:0] byte_cnt_q;
    logic [23:0]           shift_q;
    logic                  scl_q;
    logic                  sda_oe_q;
    logic                  ack_q;
    logic                  nack_q;
    logic                  active;
    logic                  tick;

    ////////////////////////////////////////
    // quarter-bit timing
    ////////////////////////////////////////

    assign active = (state_q != IDLE) && (state_q != DONE);

    // one quarter is clkdiv+1 clocks.
    assign tick = active && (qcnt_q >= i_clkdiv);

    ////////////////////////////////////////
    // byte shifter
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_cmd_req) begin
            shift_q <= {i_cmd_word.bytes.dev_byte,
                        i_cmd_word.bytes.reg_byte,
                        i_cmd_word.bytes.dat_byte};
        end else if (tick && state_q == BIT && phase_q == 2'd3) begin
            shift_q <= {shift_q[22:0], 1'b0};
        end
    end

    ////////////////////////////////////////
    // bus sequencing
    ////////////////////////////////////////

    // phases 0,1 are scl low and 2,3 scl high.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= IDLE;
            qcnt_q     <= '0;
            phase_q    <= '0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            scl_q      <= 1'b1;
            sda_oe_q   <= 1'b0;
            ack_q      <= 1'b0;
            nack_q     <= 1'b0;
        end else begin
            if (!active || tick) begin
                qcnt_q <= '0;
            end else begin
                qcnt_q <= qcnt_q + 1'b1;
            end
            if (tick) begin
                phase_q <= phase_q + 1'b1;
            end

            case (state_q)
                IDLE: begin
                    phase_q <= '0;
                    if (i_cmd_req) begin
                        // start condition, sda falls with scl high.
                        sda_oe_q   <= 1'b1;
                        bit_cnt_q  <= '0;
                        byte_cnt_q <= '0;
                        nack_q     <= 1'b0;
                        state_q    <= START;
                    end
                end
                START: begin
                    if (tick && phase_q == 2'd1) begin
                        scl_q   <= 1'b0;
                        phase_q <= '0;
                        state_q <= BIT;
                    end
                end
                BIT: begin
                    if (tick) begin
                        case (phase_q)
                            2'd0: sda_oe_q <= ~shift_q[23];
                            2'd1: scl_q <= 1'b1;
                            2'd3: begin
                                scl_q     <= 1'b0;
                                bit_cnt_q <= bit_cnt_q + 1'b1;
                                if (bit_cnt_q == LAST_BIT) begin
                                    state_q <= ACK;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                ACK: begin
                    if (tick) begin
                        case (phase_q)
                            2'd0: sda_oe_q <= 1'b0;
                            2'd1: scl_q <= 1'b1;
                            2'd2: nack_q <= i_sda;
                            default: begin
                                scl_q <= 1'b0;
                                if (nack_q || byte_cnt_q == LAST_BYTE) begin
                                    state_q <= STOP;
                                end else begin
                                    byte_cnt_q <= byte_cnt_q + 1'b1;
                                    state_q    <= BIT;
                                end
                            end
                        endcase
                    end
                end
                STOP: begin
                    if (tick) begin
                        case (phase_q)
                            2'd0: sda_oe_q <= 1'b1;
                            2'd1: scl_q <= 1'b1;
                            2'd3: begin
                                // sda rises with scl high.
                                sda_oe_q <= 1'b0;
                                ack_q    <= 1'b1;
                                state_q  <= DONE;
                            end
                            default: ;
                        endcase
                    end
                end
                DONE: begin
                    if (!i_cmd_req) begin
                        ack_q   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign o_cmd_ack  = ack_q;
    assign o_cmd_nack = nack_q;
    assign o_scl      = scl_q;
    assign o_sda_oe   = sda_oe_q;

endmodule

/* src/codec_init_regs.sv */
`timescale 1ns/100ps

module codec_init_regs
    import codec_pkg::*;
#(
    parameter int DIV_W     = 16,
    parameter int DIV_RESET = 24
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_reg_wr,
    input  logic [1:0]           i_reg_addr,
    input  logic [15:0]          i_reg_wdata,
    input  logic                 i_busy,
    input  logic                 i_done,
    input  logic                 i_nack_err,
    input  logic [CMD_IDX_W-1:0] i_cmd_idx,
    output logic [15:0]          o_reg_rdata,
    output logic                 o_start,
    output logic [DIV_W-1:0]     o_clkdiv
);

    logic [DIV_W-1:0] div_q;
    logic             start_q;
    status_t          status;

    ////////////////////////////////////////
    // host writes
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_q   <= DIV_W'(DIV_RESET);
            start_q <= 1'b0;
        end else begin
            // ctrl bit 0 is self clearing.
            start_q <= i_reg_wr && (i_reg_addr == REG_CTRL) && i_reg_wdata[0];
            if (i_reg_wr && (i_reg_addr == REG_CLKDIV)) begin
                div_q <= i_reg_wdata[DIV_W-1:0];
            end
        end
    end

    assign o_start  = start_q;
    assign o_clkdiv = div_q;

    ////////////////////////////////////////
    // host reads
    ////////////////////////////////////////

    always_comb begin
        status          = '0;
        status.busy     = i_busy;
        status.done     = i_done;
        status.nack_err = i_nack_err;
        status.cmd_idx  = i_cmd_idx;
    end

    always_comb begin
        case (i_reg_addr)
            REG_CLKDIV: o_reg_rdata = 16'(div_q);
            REG_STATUS: o_reg_rdata = status;
            default:    o_reg_rdata = 16'h0000;
        endcase
    end

endmodule

/* src/codec_init_top.sv */
`timescale 1ns/100ps

module codec_init_top
    import codec_pkg::*;
#(
    parameter int DIV_W     = 16,
    parameter int DIV_RESET = 24
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_reg_wr,
    input  logic [1:0]  i_reg_addr,
    input  logic [15:0] i_reg_wdata,
    output logic [15:0] o_reg_rdata,
    output logic        o_scl,
    output logic        o_sda_oe,
    input  logic        i_sda
);

    logic                 start;
    logic [DIV_W-1:0]     clkdiv;
    logic                 busy;
    logic                 done;
    logic                 nack_err;
    logic [CMD_IDX_W-1:0] cmd_idx;
    logic                 cmd_req;
    logic                 cmd_ack;
    logic                 cmd_nack;
    codec_cmd_u           cmd_word;

    codec_init_regs #(
        .DIV_W     (DIV_W),
        .DIV_RESET (DIV_RESET)
    ) i_codec_init_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_wr    (i_reg_wr),
        .i_reg_addr  (i_reg_addr),
        .i_reg_wdata (i_reg_wdata),
        .i_busy      (busy),
        .i_done      (done),
        .i_nack_err  (nack_err),
        .i_cmd_idx   (cmd_idx),
        .o_reg_rdata (o_reg_rdata),
        .o_start     (start),
        .o_clkdiv    (clkdiv)
    );

    init_sequencer i_init_sequencer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (start),
        .i_cmd_ack  (cmd_ack),
        .i_cmd_nack (cmd_nack),
        .o_cmd_req  (cmd_req),
        .o_cmd_word (cmd_word),
        .o_busy     (busy),
        .o_done     (done),
        .o_nack_err (nack_err),
        .o_cmd_idx  (cmd_idx)
    );

    i2c_write_engine #(
        .DIV_W (DIV_W)
    ) i_i2c_write_engine (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clkdiv   (clkdiv),
        .i_cmd_req  (cmd_req),
        .i_cmd_word (cmd_word),
        .i_sda      (i_sda),
        .o_cmd_ack  (cmd_ack),
        .o_cmd_nack (cmd_nack),
        .o_scl      (o_scl),
        .o_sda_oe   (o_sda_oe)
    );

endmodule

/* src/init_sequencer.sv */
`timescale 1ns/100ps

module init_sequencer
    import codec_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_cmd_ack,
    input  logic                 i_cmd_nack,
    output logic                 o_cmd_req,
    output codec_cmd_u           o_cmd_word,
    output logic                 o_busy,
    output logic                 o_done,
    output logic                 o_nack_err,
    output logic [CMD_IDX_W-1:0] o_cmd_idx
);

    localparam logic [1:0] SEQ_IDLE    = 2'd0;
    localparam logic [1:0] SEQ_REQ     = 2'd1;
    localparam logic [1:0] SEQ_ACK_LOW = 2'd2;

    localparam logic [CMD_IDX_W-1:0] LAST_IDX = CMD_IDX_W'(N_INIT_CMDS - 1);

    logic [1:0]           state_q;
    logic [CMD_IDX_W-1:0] idx_q;
    logic                 req_q;
    logic                 nack_seen_q;
    logic                 busy_q;
    logic                 done_q;
    logic                 nack_err_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= SEQ_IDLE;
            idx_q       <= '0;
            req_q       <= 1'b0;
            nack_seen_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            nack_err_q  <= 1'b0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (i_start) begin
                        idx_q      <= '0;
                        req_q      <= 1'b1;
                        busy_q     <= 1'b1;
                        done_q     <= 1'b0;
                        nack_err_q <= 1'b0;
                        state_q    <= SEQ_REQ;
                    end
                end
                SEQ_REQ: begin
                    if (i_cmd_ack) begin
                        req_q       <= 1'b0;
                        nack_seen_q <= i_cmd_nack;
                        state_q     <= SEQ_ACK_LOW;
                    end
                end
                SEQ_ACK_LOW: begin
                    // handshake is complete once ack drops.
                    if (!i_cmd_ack) begin
                        if (nack_seen_q) begin
                            nack_err_q <= 1'b1;
                            busy_q     <= 1'b0;
                            state_q    <= SEQ_IDLE;
                        end else if (idx_q == LAST_IDX) begin
                            done_q  <= 1'b1;
                            busy_q  <= 1'b0;
                            state_q <= SEQ_IDLE;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            req_q   <= 1'b1;
                            state_q <= SEQ_REQ;
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // index only moves with req and ack both low.
    assign o_cmd_word = INIT_TABLE[idx_q];
    assign o_cmd_req  = req_q;
    assign o_cmd_idx  = idx_q;
    assign o_busy     = busy_q;
    assign o_done     = done_q;
    assign o_nack_err = nack_err_q;

endmodule
